//--- verilog/spi_reg_pkg.sv
// spi register slave shared definitions
// command opcodes, frame phases and default field widths
// used by the slave RTL and by the testbench properties

`default_nettype none

package spi_reg_pkg;

	// ------------------------------
	// opcodes and frame phases
	// ------------------------------
	// command byte values, msb first on mosi
	typedef enum logic [7:0] {
		CMD_WR = 8'h80,
		CMD_RD = 8'h81
	} spi_cmd_e;

	// where the frame currently is
	typedef enum logic [1:0] {
		PH_CMD,
		PH_ADDR,
		PH_DATA,
		PH_IGNORE
	} spi_phase_e;

	// ------------------------------
	// default widths, multiples of 8
	// ------------------------------
	localparam int SPI_CMD_W_DEF  = 8;
	localparam int SPI_ADDR_W_DEF = 16;
	localparam int SPI_DATA_W_DEF = 16;

	// strobe length in bit clocks, slow domain samples it
	localparam int STROBE_HOLD = 4;

endpackage

`default_nettype wire

//--- verilog/spi_bit_counter.sv
// spi bit counter
// counts bits inside a byte and completed bytes inside the current field
// the field count is cleared by the frame controller on each phase change

`timescale 1ns/10ps
`default_nettype none

module spi_bit_counter (
	input  logic       i_spi_clk,
	input  logic       i_spi_cs_n,
	input  logic       i_field_clr,
	output logic [2:0] o_bit_cnt,
	output logic       o_byte_last,
	output logic [3:0] o_field_bytes
);

	logic [2:0] bit_cnt;
	logic [3:0] field_bytes;

	// ------------------------------
	// counters, held at zero while cs is high
	// ------------------------------
	always_ff @(posedge i_spi_clk or posedge i_spi_cs_n) begin
		if (i_spi_cs_n) begin
			bit_cnt     <= '0;
			field_bytes <= '0;
		end else begin
			// free running 0..7
			bit_cnt <= bit_cnt + 3'd1;
			// clear wins over a completing byte
			if (i_field_clr) begin
				field_bytes <= '0;
			end else if (bit_cnt == 3'd7) begin
				field_bytes <= field_bytes + 4'd1;
			end
		end
	end

	// high on the edge that samples bit 8 of a byte
	assign o_byte_last   = (bit_cnt == 3'd7);
	assign o_bit_cnt     = bit_cnt;
	assign o_field_bytes = field_bytes;

endmodule

`default_nettype wire

//--- verilog/spi_frame_ctrl.sv
// spi frame controller
// tracks the command, address and data phases of a frame
// decodes the command byte and issues the one-cycle load, increment
// and strobe pulses used by the rx path and the miso shifter

`timescale 1ns/10ps
`default_nettype none

module spi_frame_ctrl #(
	parameter int CMD_W  = spi_reg_pkg::SPI_CMD_W_DEF,
	parameter int ADDR_W = spi_reg_pkg::SPI_ADDR_W_DEF,
	parameter int DATA_W = spi_reg_pkg::SPI_DATA_W_DEF
) (
	input  logic              i_spi_clk,
	input  logic              i_spi_cs_n,
	input  logic [2:0]        i_bit_cnt,
	input  logic              i_byte_last,
	input  logic [3:0]        i_field_bytes,
	input  logic [DATA_W-1:0] i_shift_word,
	output logic              o_field_clr,
	output logic              o_addr_load,
	output logic              o_addr_inc,
	output logic              o_wr_load,
	output logic              o_rd_load,
	output logic              o_rd_strobe,
	output logic              o_cmd_is_rd
);

	import spi_reg_pkg::*;

	// field lengths in bytes
	localparam logic [3:0] CMD_BYTES  = 4'(CMD_W / 8);
	localparam logic [3:0] ADDR_BYTES = 4'(ADDR_W / 8);
	localparam logic [3:0] DATA_BYTES = 4'(DATA_W / 8);

	spi_phase_e phase;
	spi_cmd_e   cmd_code;
	logic       cmd_is_rd;
	logic       first_word;
	logic       rd_load;
	logic       cmd_done;
	logic       addr_done;
	logic       data_done;
	logic       addr_last;
	logic       rd_word_last;

	assign cmd_code = spi_cmd_e'(i_shift_word[CMD_W-1:0]);

	// ------------------------------
	// field boundaries
	// ------------------------------
	// done = first edge after the field, shifter holds the whole field
	assign cmd_done  = (phase == PH_CMD) && (i_bit_cnt == 3'd0) && (i_field_bytes == CMD_BYTES);
	assign addr_done = (phase == PH_ADDR) && (i_bit_cnt == 3'd0) && (i_field_bytes == ADDR_BYTES);
	assign data_done = (phase == PH_DATA) && (i_bit_cnt == 3'd0) && (i_field_bytes == DATA_BYTES);
	// last = edge sampling the final bit of the field
	assign addr_last = (phase == PH_ADDR) && i_byte_last && (i_field_bytes == ADDR_BYTES - 4'd1);
	assign rd_word_last = (phase == PH_DATA) && cmd_is_rd && i_byte_last &&
		(i_field_bytes == DATA_BYTES - 4'd1);

	// pulses, consumed on the same rising edge
	assign o_field_clr = cmd_done | addr_done | data_done;
	assign o_addr_load = addr_last;
	assign o_rd_strobe = (addr_last && cmd_is_rd) || rd_word_last;
	assign o_wr_load   = data_done && !cmd_is_rd;
	// reads pre-increment, writes step after the first word
	assign o_addr_inc  = rd_word_last || (o_wr_load && !first_word);

	// ------------------------------
	// phase fsm
	// ------------------------------
	always_ff @(posedge i_spi_clk or posedge i_spi_cs_n) begin
		if (i_spi_cs_n) begin
			phase      <= PH_CMD;
			cmd_is_rd  <= 1'b0;
			first_word <= 1'b0;
			rd_load    <= 1'b0;
		end else begin
			// miso shifter captures on the falling edge after a strobe
			rd_load <= o_rd_strobe;
			case (phase)
				PH_CMD: begin
					if (cmd_done) begin
						case (cmd_code)
							CMD_WR:  phase <= PH_ADDR;
							CMD_RD: begin
								phase     <= PH_ADDR;
								cmd_is_rd <= 1'b1;
							end
							// unknown opcode, rest of frame dropped
							default: phase <= PH_IGNORE;
						endcase
					end
				end
				PH_ADDR: begin
					if (addr_done) begin
						phase      <= PH_DATA;
						first_word <= 1'b1;
					end
				end
				PH_DATA: begin
					if (o_wr_load) begin
						first_word <= 1'b0;
					end
				end
				default: phase <= PH_IGNORE;
			endcase
		end
	end

	assign o_rd_load   = rd_load;
	assign o_cmd_is_rd = cmd_is_rd;

endmodule

`default_nettype wire

//--- verilog/spi_rx_path.sv
// spi receive path
// mosi shift register, address register and write data register
// stretches the write and read strobes so a slower register domain
// can sample them

`timescale 1ns/10ps
`default_nettype none

module spi_rx_path #(
	parameter int ADDR_W = spi_reg_pkg::SPI_ADDR_W_DEF,
	parameter int DATA_W = spi_reg_pkg::SPI_DATA_W_DEF
) (
	input  logic              i_spi_clk,
	input  logic              i_spi_cs_n,
	input  logic              i_spi_mosi,
	input  logic              i_addr_load,
	input  logic              i_addr_inc,
	input  logic              i_wr_load,
	input  logic              i_rd_strobe,
	input  logic [2:0]        i_bit_cnt,
	output logic [DATA_W-1:0] o_shift_word,
	output logic [ADDR_W-1:0] o_addr,
	output logic [DATA_W-1:0] o_wr_data,
	output logic              o_wr_en,
	output logic              o_rd_en
);

	import spi_reg_pkg::*;

	// write starts at bit count 0, read at bit count 7
	localparam logic [2:0] WR_END_CNT = 3'(STROBE_HOLD);
	localparam logic [2:0] RD_END_CNT = 3'(STROBE_HOLD - 1);

	logic [DATA_W-1:0] shift_word;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wr_data;
	logic              wr_en;
	logic              rd_en;

	// ------------------------------
	// data registers
	// ------------------------------
	always_ff @(posedge i_spi_clk) begin
		// msb first
		shift_word <= {shift_word[DATA_W-2:0], i_spi_mosi};
		// address load includes the bit sampled on this edge
		if (i_addr_load) begin
			addr <= {shift_word[ADDR_W-2:0], i_spi_mosi};
		end else if (i_addr_inc) begin
			addr <= addr + 1'b1;
		end
		if (i_wr_load) begin
			wr_data <= shift_word;
		end
	end

	// ------------------------------
	// strobe stretch
	// ------------------------------
	// end point taken from the bit count, STROBE_HOLD edges later
	always_ff @(posedge i_spi_clk or posedge i_spi_cs_n) begin
		if (i_spi_cs_n) begin
			wr_en <= 1'b0;
			rd_en <= 1'b0;
		end else begin
			if (i_wr_load) begin
				wr_en <= 1'b1;
			end else if (i_bit_cnt == WR_END_CNT) begin
				wr_en <= 1'b0;
			end
			if (i_rd_strobe) begin
				rd_en <= 1'b1;
			end else if (i_bit_cnt == RD_END_CNT) begin
				rd_en <= 1'b0;
			end
		end
	end

	assign o_shift_word = shift_word;
	assign o_addr       = addr;
	assign o_wr_data    = wr_data;
	assign o_wr_en      = wr_en;
	assign o_rd_en      = rd_en;

endmodule

`default_nettype wire

//--- verilog/spi_miso_shifter.sv
// spi miso shifter
// picks the read source by priority, captures it on the falling clock
// edge and rotates it out msb first; also drives the miso enable for
// the external tri-state buffer

`timescale 1ns/10ps
`default_nettype none

module spi_miso_shifter #(
	parameter int DATA_W = spi_reg_pkg::SPI_DATA_W_DEF
) (
	input  logic              i_spi_clk,
	input  logic              i_spi_cs_n,
	input  logic              i_rd_load,
	input  logic              i_fix_sel,
	input  logic [DATA_W-1:0] i_fix_rd_data,
	input  logic              i_pix_sel,
	input  logic [DATA_W-1:0] i_pix_rd_data,
	input  logic              i_gpif_sel,
	input  logic [DATA_W-1:0] i_gpif_rd_data,
	output logic              o_spi_miso,
	output logic              o_spi_miso_en
);

	logic [DATA_W-1:0] sel_word;
	logic [DATA_W-1:0] rd_word;
	logic              miso_en;

	// ------------------------------
	// source priority: fix, pix, gpif
	// ------------------------------
	always_comb begin
		if (i_fix_sel) begin
			sel_word = i_fix_rd_data;
		end else if (i_pix_sel) begin
			sel_word = i_pix_rd_data;
		end else if (i_gpif_sel) begin
			sel_word = i_gpif_rd_data;
		end else begin
			sel_word = '0;
		end
	end

	// falling edge: master samples on the next rising edge
	always_ff @(negedge i_spi_clk) begin
		if (i_rd_load) begin
			rd_word <= sel_word;
		end else begin
			rd_word <= {rd_word[DATA_W-2:0], rd_word[DATA_W-1]};
		end
	end

	// enable from first capture until cs rises
	always_ff @(negedge i_spi_clk or posedge i_spi_cs_n) begin
		if (i_spi_cs_n) begin
			miso_en <= 1'b0;
		end else if (i_rd_load) begin
			miso_en <= 1'b1;
		end
	end

	assign o_spi_miso    = rd_word[DATA_W-1];
	assign o_spi_miso_en = miso_en;

endmodule

`default_nettype wire

//--- verilog/spi_slave_top.sv
// spi register access slave, top level
// command, address and data frames from the master become parallel
// register bank strobes; read data returns on miso

`timescale 1ns/10ps
`default_nettype none

module spi_slave_top #(
	parameter int CMD_W  = spi_reg_pkg::SPI_CMD_W_DEF,
	parameter int ADDR_W = spi_reg_pkg::SPI_ADDR_W_DEF,
	parameter int DATA_W = spi_reg_pkg::SPI_DATA_W_DEF
) (
	input  logic              i_spi_clk,
	input  logic              i_spi_cs_n,
	input  logic              i_spi_mosi,
	output logic              o_spi_miso,
	output logic              o_spi_miso_en,
	output logic              o_wr_en,
	output logic              o_rd_en,
	output logic              o_cmd_is_rd,
	output logic [ADDR_W-1:0] o_addr,
	output logic [DATA_W-1:0] o_wr_data,
	input  logic              i_fix_sel,
	input  logic [DATA_W-1:0] i_fix_rd_data,
	input  logic              i_pix_sel,
	input  logic [DATA_W-1:0] i_pix_rd_data,
	input  logic              i_gpif_sel,
	input  logic [DATA_W-1:0] i_gpif_rd_data
);

	logic [2:0]        bit_cnt;
	logic              byte_last;
	logic [3:0]        field_bytes;
	logic              field_clr;
	logic              addr_load;
	logic              addr_inc;
	logic              wr_load;
	logic              rd_load;
	logic              rd_strobe;
	logic [DATA_W-1:0] shift_word;

	// ------------------------------
	// bit and byte counting
	// ------------------------------
	spi_bit_counter spi_bit_counter_i (
		.i_spi_clk    (i_spi_clk),
		.i_spi_cs_n   (i_spi_cs_n),
		.i_field_clr  (field_clr),
		.o_bit_cnt    (bit_cnt),
		.o_byte_last  (byte_last),
		.o_field_bytes(field_bytes)
	);

	spi_frame_ctrl #(.CMD_W(CMD_W), .ADDR_W(ADDR_W), .DATA_W(DATA_W)) spi_frame_ctrl_i (
		.i_spi_clk(i_spi_clk), .i_spi_cs_n(i_spi_cs_n), .i_bit_cnt(bit_cnt),
		.i_byte_last(byte_last), .i_field_bytes(field_bytes), .i_shift_word(shift_word),
		.o_field_clr(field_clr), .o_addr_load(addr_load), .o_addr_inc(addr_inc),
		.o_wr_load(wr_load), .o_rd_load(rd_load), .o_rd_strobe(rd_strobe),
		.o_cmd_is_rd(o_cmd_is_rd)
	);

	// ------------------------------
	// data paths
	// ------------------------------
	spi_rx_path #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) spi_rx_path_i (
		.i_spi_clk(i_spi_clk), .i_spi_cs_n(i_spi_cs_n), .i_spi_mosi(i_spi_mosi),
		.i_addr_load(addr_load), .i_addr_inc(addr_inc), .i_wr_load(wr_load),
		.i_rd_strobe(rd_strobe), .i_bit_cnt(bit_cnt), .o_shift_word(shift_word),
		.o_addr(o_addr), .o_wr_data(o_wr_data), .o_wr_en(o_wr_en), .o_rd_en(o_rd_en)
	);

	spi_miso_shifter #(.DATA_W(DATA_W)) spi_miso_shifter_i (
		.i_spi_clk(i_spi_clk), .i_spi_cs_n(i_spi_cs_n), .i_rd_load(rd_load),
		.i_fix_sel(i_fix_sel), .i_fix_rd_data(i_fix_rd_data),
		.i_pix_sel(i_pix_sel), .i_pix_rd_data(i_pix_rd_data),
		.i_gpif_sel(i_gpif_sel), .i_gpif_rd_data(i_gpif_rd_data),
		.o_spi_miso(o_spi_miso), .o_spi_miso_en(o_spi_miso_en)
	);

endmodule

`default_nettype wire

//--- verif/spi_slave_properties.sv
// spi slave strobe properties
// bound into the top level; checks idle state while deselected
// and the stretched length of the write and read strobes

`timescale 1ns/10ps
`default_nettype none

module spi_slave_properties (
	input logic i_spi_clk,
	input logic i_spi_cs_n,
	input logic i_wr_en,
	input logic i_rd_en,
	input logic i_spi_miso_en,
	input logic i_cmd_is_rd
);

	import spi_reg_pkg::*;

	// failures seen so far, read by the testbench
	int fail_cnt = 0;

	// ------------------------------
	// deselected frame logic is idle
	// ------------------------------
	cs_idle: assert property (@(posedge i_spi_clk)
		i_spi_cs_n |-> !i_wr_en && !i_rd_en && !i_spi_miso_en && !i_cmd_is_rd)
		else begin
			fail_cnt++;
			$error("strobe, read flag or miso enable high while deselected");
		end

	// write strobe lasts STROBE_HOLD bit clocks
	wr_hold: assert property (@(posedge i_spi_clk) disable iff (i_spi_cs_n)
		$rose(i_wr_en) |-> i_wr_en [*STROBE_HOLD] ##1 !i_wr_en)
		else begin
			fail_cnt++;
			$error("write strobe length differs from STROBE_HOLD");
		end

	// same for the read strobe
	rd_hold: assert property (@(posedge i_spi_clk) disable iff (i_spi_cs_n)
		$rose(i_rd_en) |-> i_rd_en [*STROBE_HOLD] ##1 !i_rd_en)
		else begin
			fail_cnt++;
			$error("read strobe length differs from STROBE_HOLD");
		end

endmodule

`default_nettype wire

//--- verif/spi_slave_checker.sv
// spi slave checker
// decodes the mosi frame on its own, predicts write and read strobes and
// miso read words from the register bank rules and compares them

`timescale 1ns/10ps
`default_nettype none

module spi_slave_checker #(
	parameter int CMD_W  = spi_reg_pkg::SPI_CMD_W_DEF,
	parameter int ADDR_W = spi_reg_pkg::SPI_ADDR_W_DEF,
	parameter int DATA_W = spi_reg_pkg::SPI_DATA_W_DEF
) (
	input  logic              i_spi_clk,
	input  logic              i_spi_cs_n,
	input  logic              i_spi_mosi,
	input  logic              i_spi_miso,
	input  logic              i_spi_miso_en,
	input  logic              i_wr_en,
	input  logic              i_rd_en,
	input  logic              i_cmd_is_rd,
	input  logic [ADDR_W-1:0] i_addr,
	input  logic [DATA_W-1:0] i_wr_data,
	input  logic              i_fix_sel,
	input  logic              i_pix_sel,
	input  logic              i_gpif_sel,
	input  logic [DATA_W-1:0] i_gpif_rd_data,
	output int                o_err_cnt,
	output int                o_wr_cnt,
	output int                o_rd_cnt
);

	import spi_reg_pkg::*;

	// bits before the first data word
	localparam int HDR_BITS = CMD_W + ADDR_W;

	logic [CMD_W-1:0]  cmd_rx;
	logic [ADDR_W-1:0] addr_rx;
	logic [ADDR_W-1:0] exp_addr;
	logic [DATA_W-1:0] data_rx;
	logic [DATA_W-1:0] miso_rx;
	logic [DATA_W-1:0] exp_word;
	logic [DATA_W-1:0] wr_q [$];
	logic              wr_en_q;
	logic              rd_en_q;
	int                bit_idx;
	int                pos;
	int                word_k;
	int                wr_k;
	int                err_cnt = 0;
	int                wr_cnt = 0;
	int                rd_cnt = 0;

	// register bank: fix is constant, pix follows the address
	function automatic logic [DATA_W-1:0] ref_read_word(input logic fix_sel,
		input logic pix_sel, input logic gpif_sel, input logic [ADDR_W-1:0] a,
		input logic [DATA_W-1:0] gpif_data);
		if (fix_sel) begin
			return DATA_W'(16'h1234);
		end else if (pix_sel) begin
			return DATA_W'(a ^ 16'hA5C3);
		end else if (gpif_sel) begin
			return gpif_data;
		end
		return '0;
	endfunction

	// ------------------------------
	// frame monitor
	// ------------------------------
	always @(posedge i_spi_clk) begin
		if (i_spi_cs_n) begin
			if (wr_q.size() != 0) begin
				err_cnt++;
				$display("a received write word got no write strobe before chip select rose");
				wr_q.delete();
			end
			bit_idx = 0;
			wr_k    = 0;
			wr_en_q = 1'b0;
			rd_en_q = 1'b0;
			cmd_rx  = '0;
		end else begin
			// enable only belongs to the data phase of a read
			if (i_spi_miso_en && (bit_idx < HDR_BITS || cmd_rx != CMD_RD)) begin
				err_cnt++;
				$display("error at %0t: miso enable high outside the read data phase", $time);
			end
			// read strobe seen one edge after the address and after each read word
			if (i_rd_en && !rd_en_q) begin
				rd_cnt++;
				if (cmd_rx != CMD_RD || bit_idx < HDR_BITS ||
					(bit_idx - HDR_BITS) % DATA_W != 0) begin
					err_cnt++;
					$display("error at %0t: read strobe at frame bit %0d", $time, bit_idx);
				end else begin
					exp_addr = addr_rx + ADDR_W'((bit_idx - HDR_BITS) / DATA_W);
					if (i_addr !== exp_addr) begin
						err_cnt++;
						$display("error at %0t: read strobe addr 0x%h expected 0x%h",
							$time, i_addr, exp_addr);
					end
				end
			end
			rd_en_q = i_rd_en;
			if (bit_idx < CMD_W) begin
				cmd_rx = {cmd_rx[CMD_W-2:0], i_spi_mosi};
			end else if (bit_idx < HDR_BITS) begin
				addr_rx = {addr_rx[ADDR_W-2:0], i_spi_mosi};
			end else begin
				pos     = (bit_idx - HDR_BITS) % DATA_W;
				word_k  = (bit_idx - HDR_BITS) / DATA_W;
				data_rx = {data_rx[DATA_W-2:0], i_spi_mosi};
				miso_rx = {miso_rx[DATA_W-2:0], i_spi_miso};
				if (cmd_rx == CMD_RD && !(i_spi_miso_en && i_cmd_is_rd)) begin
					err_cnt++;
					$display("error at %0t: miso enable or read flag low in read data", $time);
				end
				// read word k comes from address A+k
				if (pos == DATA_W - 1 && cmd_rx == CMD_RD) begin
					exp_addr = addr_rx + ADDR_W'(word_k);
					exp_word = ref_read_word(i_fix_sel, i_pix_sel, i_gpif_sel, exp_addr,
						i_gpif_rd_data);
					if (miso_rx !== exp_word) begin
						err_cnt++;
						$display("error at %0t: read word %0d addr 0x%h got 0x%h expected 0x%h",
							$time, word_k, exp_addr, miso_rx, exp_word);
					end
				end
				if (pos == DATA_W - 1 && cmd_rx == CMD_WR) begin
					wr_q.push_back(data_rx);
				end
			end
			// rising write strobe, k-th word at A+k
			if (i_wr_en && !wr_en_q) begin
				wr_cnt++;
				if (cmd_rx != CMD_WR || wr_q.size() == 0) begin
					err_cnt++;
					$display("error at %0t: write strobe without a received write word", $time);
				end else begin
					exp_addr = addr_rx + ADDR_W'(wr_k);
					exp_word = wr_q.pop_front();
					if (i_addr !== exp_addr || i_wr_data !== exp_word) begin
						err_cnt++;
						$display("error at %0t: write %0d got 0x%h 0x%h expected 0x%h 0x%h",
							$time, wr_k, i_addr, i_wr_data, exp_addr, exp_word);
					end
					wr_k++;
				end
			end
			wr_en_q = i_wr_en;
			bit_idx++;
		end
	end

	assign o_err_cnt = err_cnt;
	assign o_wr_cnt  = wr_cnt;
	assign o_rd_cnt  = rd_cnt;

endmodule

`default_nettype wire

//--- verif/spi_slave_tb.sv
// testbench for the spi register access slave
// drives write, read and ignored frames, models the register bank
// read sources and prints the final report

`timescale 1ns/10ps
`default_nettype none

module spi_slave_tb;

	import spi_reg_pkg::*;

	localparam int CMD_W      = SPI_CMD_W_DEF;
	localparam int ADDR_W     = SPI_ADDR_W_DEF;
	localparam int DATA_W     = SPI_DATA_W_DEF;
	localparam int WAIT_LIMIT = 200;

	logic              spi_clk;
	logic              spi_cs_n;
	logic              spi_mosi;
	logic              spi_miso;
	logic              spi_miso_en;
	logic              wr_en;
	logic              rd_en;
	logic              cmd_is_rd;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wr_data;
	logic              fix_sel;
	logic [DATA_W-1:0] fix_rd_data;
	logic              pix_sel;
	logic [DATA_W-1:0] pix_rd_data;
	logic              gpif_sel;
	logic [DATA_W-1:0] gpif_rd_data;
	logic [DATA_W-1:0] tx_words [0:7];
	integer            seed;
	int                tb_err_cnt;
	int                chk_err_cnt;
	int                wr_cnt;
	int                rd_cnt;
	int                assert_fails;

	// 20 ns bit clock
	always #10 spi_clk = ~spi_clk;

	// register bank model, pix source follows the address
	assign pix_rd_data = addr ^ 16'hA5C3;

	spi_slave_top #(.CMD_W(CMD_W), .ADDR_W(ADDR_W), .DATA_W(DATA_W)) spi_slave_top_i (
		.i_spi_clk(spi_clk), .i_spi_cs_n(spi_cs_n), .i_spi_mosi(spi_mosi),
		.o_spi_miso(spi_miso), .o_spi_miso_en(spi_miso_en),
		.o_wr_en(wr_en), .o_rd_en(rd_en), .o_cmd_is_rd(cmd_is_rd),
		.o_addr(addr), .o_wr_data(wr_data),
		.i_fix_sel(fix_sel), .i_fix_rd_data(fix_rd_data),
		.i_pix_sel(pix_sel), .i_pix_rd_data(pix_rd_data),
		.i_gpif_sel(gpif_sel), .i_gpif_rd_data(gpif_rd_data)
	);

	spi_slave_checker #(.CMD_W(CMD_W), .ADDR_W(ADDR_W), .DATA_W(DATA_W)) spi_slave_checker_i (
		.i_spi_clk(spi_clk), .i_spi_cs_n(spi_cs_n), .i_spi_mosi(spi_mosi),
		.i_spi_miso(spi_miso), .i_spi_miso_en(spi_miso_en),
		.i_wr_en(wr_en), .i_rd_en(rd_en), .i_cmd_is_rd(cmd_is_rd),
		.i_addr(addr), .i_wr_data(wr_data),
		.i_fix_sel(fix_sel), .i_pix_sel(pix_sel), .i_gpif_sel(gpif_sel),
		.i_gpif_rd_data(gpif_rd_data),
		.o_err_cnt(chk_err_cnt), .o_wr_cnt(wr_cnt), .o_rd_cnt(rd_cnt)
	);

	bind spi_slave_top spi_slave_properties spi_slave_properties_i (
		.i_spi_clk(i_spi_clk), .i_spi_cs_n(i_spi_cs_n),
		.i_wr_en(o_wr_en), .i_rd_en(o_rd_en),
		.i_spi_miso_en(o_spi_miso_en), .i_cmd_is_rd(o_cmd_is_rd)
	);

	// ------------------------------
	// frame driver
	// ------------------------------
	// msb first, mosi moves 2 ns after the rising edge
	task automatic send_bits(input logic [15:0] val, input int nbits);
		int i;
		for (i = nbits - 1; i >= 0; i--) begin
			spi_mosi = val[i];
			@(posedge spi_clk);
			#2;
		end
	endtask

	// cs high two cycles, header, words, then a few idle bits for the strobes
	task automatic run_frame(input logic [7:0] cmd, input logic [15:0] a, input int n);
		int i;
		spi_cs_n = 1'b1;
		repeat (2) @(posedge spi_clk);
		#2;
		spi_cs_n = 1'b0;
		send_bits(16'(cmd), CMD_W);
		send_bits(a, ADDR_W);
		for (i = 0; i < n; i++) begin
			send_bits(tx_words[i], DATA_W);
		end
		spi_mosi = 1'b0;
		repeat (6) @(posedge spi_clk);
		#2;
		spi_cs_n = 1'b1;
	endtask

	// wait for the checker to see the strobes, then demand the exact count
	task automatic wait_for_count(input logic is_rd, input int expected);
		int cycles;
		int seen;
		cycles = 0;
		seen   = is_rd ? rd_cnt : wr_cnt;
		while (seen < expected && cycles < WAIT_LIMIT) begin
			@(negedge spi_clk);
			cycles++;
			seen = is_rd ? rd_cnt : wr_cnt;
		end
		if (seen < expected) begin
			tb_err_cnt++;
			$display("timeout waiting for %0s strobes from the slave", is_rd ? "read" : "write");
		end else if (seen != expected) begin
			tb_err_cnt++;
			$display("error at %0t: %0d %0s strobes seen, expected %0d", $time, seen,
				is_rd ? "read" : "write", expected);
		end
	endtask

	task automatic run_test(input logic [7:0] cmd, input int n, input logic fix,
		input logic pix, input logic gpif);
		int wr_base;
		int rd_base;
		int i;
		wr_base  = wr_cnt;
		rd_base  = rd_cnt;
		fix_sel  = fix;
		pix_sel  = pix;
		gpif_sel = gpif;
		for (i = 0; i < n; i++) begin
			tx_words[i] = 16'($random(seed));
		end
		run_frame(cmd, 16'($random(seed)), n);
		wait_for_count(1'b0, wr_base + ((cmd == CMD_WR) ? n : 0));
		// one read strobe after the address, one more at the end of each word
		wait_for_count(1'b1, rd_base + ((cmd == CMD_RD) ? n + 1 : 0));
	endtask

	initial begin
		seed         = 24355;
		tb_err_cnt   = 0;
		spi_clk      = 1'b0;
		spi_mosi     = 1'b0;
		fix_sel      = 1'b0;
		pix_sel      = 1'b0;
		gpif_sel     = 1'b0;
		fix_rd_data  = 16'h1234;
		gpif_rd_data = 16'h5A0F;
		// clean chip select edge clears the frame logic
		spi_cs_n     = 1'b0;
		#1;
		spi_cs_n     = 1'b1;
		// single and burst writes
		run_test(CMD_WR, 1, 1'b0, 1'b1, 1'b0);
		run_test(CMD_WR, 4, 1'b0, 1'b1, 1'b0);
		// reads from the pix source
		run_test(CMD_RD, 1, 1'b0, 1'b1, 1'b0);
		run_test(CMD_RD, 3, 1'b0, 1'b1, 1'b0);
		// source priority, fix over pix, then gpif only, then nothing
		run_test(CMD_RD, 2, 1'b1, 1'b1, 1'b0);
		run_test(CMD_RD, 1, 1'b0, 1'b0, 1'b1);
		run_test(CMD_RD, 1, 1'b0, 1'b0, 1'b0);
		// unknown opcode, frame ignored
		run_test(8'h42, 2, 1'b0, 1'b1, 1'b0);
		repeat (2) @(posedge spi_clk);
		assert_fails = spi_slave_top_i.spi_slave_properties_i.fail_cnt;
		$display("errors: checker %0d, testbench %0d, assertions %0d; writes %0d, reads %0d",
			chk_err_cnt, tb_err_cnt, assert_fails, wr_cnt, rd_cnt);
		if (chk_err_cnt + tb_err_cnt + assert_fails == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
verilog/spi_reg_pkg.sv
verilog/spi_bit_counter.sv
verilog/spi_frame_ctrl.sv
verilog/spi_rx_path.sv
verilog/spi_miso_shifter.sv
verilog/spi_slave_top.sv
verif/spi_slave_properties.sv
verif/spi_slave_checker.sv
verif/spi_slave_tb.sv

//--- Bender.yml
package:
  name: spi_reg_slave

sources:
  - verilog/spi_reg_pkg.sv
  - verilog/spi_bit_counter.sv
  - verilog/spi_frame_ctrl.sv
  - verilog/spi_rx_path.sv
  - verilog/spi_miso_shifter.sv
  - verilog/spi_slave_top.sv
  - target: test
    files:
      - verif/spi_slave_properties.sv
      - verif/spi_slave_checker.sv
      - verif/spi_slave_tb.sv
